//--- common/pmcc_bus_pkg.sv
// *************************************************************************
// Bus-level types shared by the data decoder, the slaves and the interface.
// *************************************************************************

package pmcc_bus_pkg;

    // Every slave on the data bus carries one 32-bit word per access.
    localparam int WORD_WIDTH = 32;

    // One byte lane per byte of the word.
    localparam int BYTES_PER_WORD = WORD_WIDTH / 8;

    typedef logic [WORD_WIDTH-1:0] word_t;   // Data word on either port.
    typedef logic [31:0] addr_t;             // Byte address.

    // Byte enables, where bit i qualifies bits 8*i+7 down to 8*i of the word.
    typedef logic [BYTES_PER_WORD-1:0] be_t;

endpackage

//--- common/pmcc_mem_pkg.sv
// *************************************************************************
// Memory map of the data bus. The top nibble of the address picks a region.
// *************************************************************************

package pmcc_mem_pkg;

    // Region select field inside a byte address.
    localparam int REGION_MSB = 31;
    localparam int REGION_LSB = 28;

    typedef logic [REGION_MSB-REGION_LSB:0] region_t;   // Region code.
    typedef logic [REGION_LSB-1:0] ofs_t;                // Offset inside a region.

    // Region codes. Codes 2 and above are unmapped and raise a decode error.
    localparam region_t RAM_REGION  = region_t'(0);
    localparam region_t GPIO_REGION = region_t'(1);

    // GPIO register offsets. The output register is read/write.
    localparam ofs_t GPIO_OUT_OFS = ofs_t'(0);
    // The input register is read-only and returns the synchronized pins.
    localparam ofs_t GPIO_IN_OFS  = ofs_t'(4);

    // RAM size in bytes when the top level is not told otherwise.
    localparam int DEFAULT_RAM_DEPTH = 1024;

endpackage

//--- common/pmcc_data_if.sv
// *************************************************************************
// Data bus between the region decoder and one slave.
// *************************************************************************
// An access happens on every rising edge with req high. The slave returns
// rdata one cycle later, and there is no handshake or back-pressure.

interface pmcc_data_if;

    import pmcc_bus_pkg::*;

    logic  req;     // Access strobe, one cycle per access.
    addr_t addr;    // Byte address of the access.
    logic  we;      // High for a write, low for a read.
    be_t   be;      // Byte lanes written when we is high.
    word_t wdata;   // Write data, lane aligned.
    word_t rdata;   // Read data, valid the cycle after req.

    // The decoder side drives the request.
    modport master (
        output req, addr, we, be, wdata,
        input  rdata
    );

    // The slave side only returns read data.
    modport slave (
        input  req, addr, we, be, wdata,
        output rdata
    );

endinterface

//--- ram/pmcc_dpram.sv
// *************************************************************************
// Dual-port byte-organized RAM.
// *************************************************************************
// Port A serves the data bus (read/write with byte enables) and port B
// serves instruction fetch (read on every clock). Byte addresses wrap
// modulo DEPTH on both ports.

module pmcc_dpram #(
    parameter int DEPTH = 1024
) (
    input  logic                clk,
    pmcc_data_if.slave          a,
    input  pmcc_bus_pkg::addr_t instr_addr,
    output pmcc_bus_pkg::word_t instr_rdata
);

    import pmcc_bus_pkg::*;

    localparam int AW = $clog2(DEPTH);          // Byte index width.
    localparam int ALIGN_BITS = $clog2(BYTES_PER_WORD);

    logic [7:0]    mem [DEPTH];                 // Byte storage, no reset.
    logic [AW-1:0] a_idx [BYTES_PER_WORD];      // Port A byte index per lane.
    logic [AW-1:0] b_idx [BYTES_PER_WORD];      // Port B byte index per lane.

    // Lane i lives at base + i. The AW-bit sum wraps at the end of the array.
    always_comb begin
        for (int i = 0; i < BYTES_PER_WORD; i++) begin
            a_idx[i] = a.addr[AW-1:0] + AW'(i);
            b_idx[i] = instr_addr[AW-1:0] + AW'(i);
        end
    end

    // Port A writes the enabled lanes and reads all four when requested.
    // Nonblocking assignment gives old data on a read-during-write.
    always_ff @(posedge clk) begin
        for (int i = 0; i < BYTES_PER_WORD; i++) begin
            if (a.req && a.we && a.be[i])
                mem[a_idx[i]] <= a.wdata[8*i +: 8];
            if (a.req)
                a.rdata[8*i +: 8] <= mem[a_idx[i]];   // Holds while req is low.
        end
    end

    // Port B fetches a word every clock regardless of port A.
    always_ff @(posedge clk) begin
        for (int i = 0; i < BYTES_PER_WORD; i++)
            instr_rdata[8*i +: 8] <= mem[b_idx[i]];
    end

    // *********************************************************************
    // Checks.
    // *********************************************************************

    // The wrap arithmetic above only works for a power-of-two byte count.
    if (DEPTH < BYTES_PER_WORD || (DEPTH & (DEPTH - 1)) != 0) begin : g_bad_depth
        $error("pmcc_dpram DEPTH must be a power of two of at least one word.");
    end

    // Data accesses are whole words at aligned addresses.
    a_req_aligned: assert property (
        @(posedge clk) a.req |-> (a.addr[ALIGN_BITS-1:0] == '0)
    ) else $error("Port A request to unaligned address %h.", a.addr);

endmodule

//--- rtl/pmcc_data_bus.sv
// *************************************************************************
// Data-side region decoder.
// *************************************************************************
// The region code in the top address bits picks RAM, GPIO or nothing. The
// request fields go to both slaves and only the strobe is steered. The
// choice is kept for one cycle to pick the returning read data.

module pmcc_data_bus (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                data_req,
    input  logic                data_we,
    input  pmcc_bus_pkg::addr_t data_addr,
    input  pmcc_bus_pkg::be_t   data_be,
    input  pmcc_bus_pkg::word_t data_wdata,
    output pmcc_bus_pkg::word_t data_rdata,
    output logic                data_err,
    pmcc_data_if.master         ram_bus,
    pmcc_data_if.master         gpio_bus
);

    import pmcc_mem_pkg::*;

    // Which slave answers in the current cycle.
    typedef enum logic [1:0] {
        SEL_NONE,   // No access last cycle.
        SEL_RAM,
        SEL_GPIO,
        SEL_ERR     // Access to an unmapped region.
    } sel_t;

    region_t region;    // Region code of the current request.
    sel_t    sel_d;     // Slave selected by the current request.
    sel_t    sel_q;     // Slave whose read data is due now.

    assign region = data_addr[REGION_MSB:REGION_LSB];

    always_comb begin
        sel_d = SEL_NONE;                       // Idle cycle.
        if (data_req) begin
            case (region)
                RAM_REGION:  sel_d = SEL_RAM;
                GPIO_REGION: sel_d = SEL_GPIO;
                default:     sel_d = SEL_ERR;
            endcase
        end
    end

    // Shared request fields. A slave ignores them without its strobe.
    assign ram_bus.addr   = data_addr;
    assign ram_bus.we     = data_we;
    assign ram_bus.be     = data_be;
    assign ram_bus.wdata  = data_wdata;
    assign gpio_bus.addr  = data_addr;
    assign gpio_bus.we    = data_we;
    assign gpio_bus.be    = data_be;
    assign gpio_bus.wdata = data_wdata;

    assign ram_bus.req  = (sel_d == SEL_RAM);   // Only the chosen slave sees req.
    assign gpio_bus.req = (sel_d == SEL_GPIO);

    // The selection lines up with the one-cycle slave latency.
    always_ff @(posedge clk) begin
        if (!rst_n)
            sel_q <= SEL_NONE;
        else
            sel_q <= sel_d;
    end

    // Return data of the slave that was addressed, or zero.
    always_comb begin
        case (sel_q)
            SEL_RAM:  data_rdata = ram_bus.rdata;
            SEL_GPIO: data_rdata = gpio_bus.rdata;
            default:  data_rdata = '0;
        endcase
    end

    assign data_err = (sel_q == SEL_ERR);       // One cycle, aligned with rdata.

    // At most one slave may be addressed per cycle.
    one_hot_strobe: assert property (
        @(posedge clk) disable iff (!rst_n) !(ram_bus.req && gpio_bus.req)
    ) else $error("RAM and GPIO strobes are high together.");

endmodule

//--- rtl/pmcc_gpio.sv
// *************************************************************************
// GPIO register block on the data bus.
// *************************************************************************
// Offset GPIO_OUT_OFS drives the output pins. Offset GPIO_IN_OFS reads the
// input pins after a two-flop synchronizer. Other offsets read as zero.

module pmcc_gpio #(
    parameter int GPIO_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    pmcc_data_if.slave            bus,
    input  logic [GPIO_WIDTH-1:0] gpio_in,
    output logic [GPIO_WIDTH-1:0] gpio_out
);

    import pmcc_bus_pkg::*;
    import pmcc_mem_pkg::*;

    ofs_t                  ofs;         // Register offset inside the region.
    logic                  out_wr;      // Write to the output register.
    word_t                 out_merged;  // Output register with new lanes merged.
    word_t                 rd_word;     // Register value for the current read.
    logic [GPIO_WIDTH-1:0] in_meta;     // First synchronizer stage.
    logic [GPIO_WIDTH-1:0] in_sync;     // Second stage, safe to read.

    assign ofs    = bus.addr[REGION_LSB-1:0];
    assign out_wr = bus.req && bus.we && (ofs == GPIO_OUT_OFS);

    // Replace only the enabled byte lanes of the current output value.
    always_comb begin
        out_merged = word_t'(gpio_out);
        for (int i = 0; i < BYTES_PER_WORD; i++)
            if (bus.be[i])
                out_merged[8*i +: 8] = bus.wdata[8*i +: 8];
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            gpio_out <= '0;
        else if (out_wr)
            gpio_out <= out_merged[GPIO_WIDTH-1:0];  // Lanes above the width drop.
    end

    // Pins are asynchronous to clk, so they pass two flops first.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_meta <= '0;
            in_sync <= '0;
        end else begin
            in_meta <= gpio_in;
            in_sync <= in_meta;
        end
    end

    // Register read mux, zero-extended to the bus word.
    always_comb begin
        case (ofs)
            GPIO_OUT_OFS: rd_word = word_t'(gpio_out);
            GPIO_IN_OFS:  rd_word = word_t'(in_sync);
            default:      rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (bus.req)
            bus.rdata <= rd_word;               // A write returns the old value.
    end

    // The pins must fit in one bus word.
    if (GPIO_WIDTH < 1 || GPIO_WIDTH > 32) begin : g_bad_width
        $error("pmcc_gpio GPIO_WIDTH must be between 1 and 32.");
    end

    // Outputs change only through a bus write.
    out_stable: assert property (
        @(posedge clk) disable iff (!rst_n) !(bus.req && bus.we) |=> $stable(gpio_out)
    ) else $error("gpio_out changed without a write request.");

endmodule

//--- rtl/pmcc_mem_top.sv
// *************************************************************************
// Memory subsystem top level.
// *************************************************************************
// Data accesses go through the region decoder to the RAM or the GPIO block.
// Instruction fetch reads the second RAM port directly on every clock.

module pmcc_mem_top #(
    parameter int RAM_DEPTH  = pmcc_mem_pkg::DEFAULT_RAM_DEPTH,  // Bytes, power of two.
    parameter int GPIO_WIDTH = 16                                // At most 32 pins.
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // Data port.
    input  logic                  data_req,
    input  logic                  data_we,
    input  logic [31:0]           data_addr,
    input  logic [3:0]            data_be,
    input  logic [31:0]           data_wdata,
    output logic [31:0]           data_rdata,
    output logic                  data_err,

    // Instruction port.
    input  logic [31:0]           instr_addr,
    output logic [31:0]           instr_rdata,

    // GPIO pins.
    input  logic [GPIO_WIDTH-1:0] gpio_in,
    output logic [GPIO_WIDTH-1:0] gpio_out
);

    // *********************************************************************
    // Slave buses.
    // *********************************************************************

    pmcc_data_if ram_bus ();    // Decoder to RAM port A.
    pmcc_data_if gpio_bus ();   // Decoder to the GPIO registers.

    // *********************************************************************
    // Decoder, RAM and GPIO.
    // *********************************************************************

    pmcc_data_bus u_data_bus (
        .clk        (clk),
        .rst_n      (rst_n),
        .data_req   (data_req),
        .data_we    (data_we),
        .data_addr  (data_addr),
        .data_be    (data_be),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata),
        .data_err   (data_err),
        .ram_bus    (ram_bus.master),
        .gpio_bus   (gpio_bus.master)
    );

    pmcc_dpram #(
        .DEPTH (RAM_DEPTH)
    ) u_dpram (
        .clk         (clk),
        .a           (ram_bus.slave),
        .instr_addr  (instr_addr),
        .instr_rdata (instr_rdata)
    );

    pmcc_gpio #(
        .GPIO_WIDTH (GPIO_WIDTH)
    ) u_gpio (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus      (gpio_bus.slave),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out)
    );

endmodule

//--- dv/pmcc_mem_tb.sv
// *************************************************************************
// Directed testbench for the memory subsystem top level.
// *************************************************************************

module pmcc_mem_tb;

    localparam int RAM_DEPTH  = 1024;
    localparam int GPIO_WIDTH = 16;
    localparam logic [31:0] GPIO_OUT_ADDR = 32'h1000_0000;   // Region 1, offset 0.
    localparam logic [31:0] GPIO_IN_ADDR  = 32'h1000_0004;   // Region 1, offset 4.
    localparam int POLL_LIMIT = 20;                          // Reads before giving up.

    logic clk = 1'b0;
    logic rst_n, data_req, data_we, data_err;
    logic [3:0] data_be;
    logic [31:0] data_addr, data_wdata, data_rdata, instr_addr, instr_rdata;
    logic [GPIO_WIDTH-1:0] gpio_in, gpio_out;

    logic [7:0] shadow_ram [RAM_DEPTH];     // Byte image of what the RAM should hold.
    logic [GPIO_WIDTH-1:0] shadow_out;      // Expected output register.
    logic [31:0] rnd_state;                 // Xorshift state.
    int errors, tests_ok, tests_bad;

    pmcc_mem_top #(.RAM_DEPTH(RAM_DEPTH), .GPIO_WIDTH(GPIO_WIDTH)) dut0 (.*);

    always #50 clk = ~clk;                  // Period of 100.

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rnd_state = xorshift32(rnd_state);
        return rnd_state;
    endfunction

    // Word slots used by the RAM tests, starting at byte 0x80.
    function automatic logic [31:0] ram_addr(input int idx);
        return 32'h80 + 32'(idx) * 4;
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] addr);
        logic [31:0] w;
        for (int i = 0; i < 4; i++)
            w[8*i +: 8] = shadow_ram[(addr + i) % RAM_DEPTH];   // Wraps like the RAM.
        return w;
    endfunction

    // Lanes with their enable set take the new byte, the others keep the old one.
    function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] wdata,
                                                input logic [3:0] be);
        for (int i = 0; i < 4; i++)
            if (be[i])
                old[8*i +: 8] = wdata[8*i +: 8];
        return old;
    endfunction

    task automatic shadow_write(input logic [31:0] addr, input logic [3:0] be,
                                input logic [31:0] wdata);
        logic [31:0] w;
        w = merge_lanes(shadow_word(addr), wdata, be);
        for (int i = 0; i < 4; i++)
            shadow_ram[(addr + i) % RAM_DEPTH] = w[8*i +: 8];
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR at time %0t: %s: expected %h, got %h", $time, what, expected, actual);
            errors++;
        end
    endtask

    // Puts one request on the data port. The caller is at a rising edge.
    task automatic drive_access(input logic we, input logic [31:0] addr, input logic [3:0] be,
                                input logic [31:0] wdata);
        data_req   <= 1'b1;
        data_we    <= we;
        data_addr  <= addr;
        data_be    <= be;
        data_wdata <= wdata;
    endtask

    // One isolated access. Results are sampled mid-cycle after the sampling edge.
    task automatic access(input logic we, input logic [31:0] addr, input logic [3:0] be,
                          input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
        @(posedge clk);
        drive_access(we, addr, be, wdata);
        @(posedge clk);                     // The DUT takes the request here.
        data_req <= 1'b0;
        @(negedge clk);
        rdata = data_rdata;
        err   = data_err;
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d mismatches", name, errors - errors_before);
        end
    endtask

    // *************************************************************************
    // Tests.
    // *************************************************************************

    task automatic test_word_rw();
        int start;
        logic [31:0] rd, wd;
        logic err;
        start = errors;
        for (int i = 0; i < 16; i++) begin
            wd = next_random();
            access(1'b1, ram_addr(i), 4'hf, wd, rd, err);
            check_value("word write data_err", 32'd0, err);
            shadow_write(ram_addr(i), 4'hf, wd);
        end
        for (int i = 0; i < 16; i++) begin
            access(1'b0, ram_addr(i), 4'hf, 32'd0, rd, err);
            check_value("word read data", shadow_word(ram_addr(i)), rd);
            check_value("word read data_err", 32'd0, err);
        end
        report_test("word write and read", start);
    endtask

    task automatic test_byte_enables();
        int start;
        logic [3:0] be_list [8];
        logic [31:0] rd, wd;
        logic err;
        start = errors;
        be_list = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h5, 4'ha, 4'h6, 4'h0};
        access(1'b1, 32'h300, 4'hf, 32'h1122_3344, rd, err);
        shadow_write(32'h300, 4'hf, 32'h1122_3344);
        foreach (be_list[n]) begin
            wd = next_random();
            access(1'b1, 32'h300, be_list[n], wd, rd, err);
            shadow_write(32'h300, be_list[n], wd);
            access(1'b0, 32'h300, 4'hf, 32'd0, rd, err);
            check_value("byte enable merge", shadow_word(32'h300), rd);
        end
        report_test("byte enables", start);
    endtask

    // Fetch the test 1 words while the data port writes elsewhere.
    task automatic test_instr_port();
        int start;
        start = errors;
        for (int k = 0; k <= 16; k++) begin
            @(posedge clk);
            if (k < 16) begin
                instr_addr <= ram_addr(k);
                drive_access(1'b1, 32'h200 + 32'(k) * 4, 4'hf, next_random());
            end else
                data_req <= 1'b0;
            if (k > 0) begin
                @(negedge clk);             // Fetch of slot k-1 was taken at this edge.
                check_value("instruction fetch", shadow_word(ram_addr(k - 1)), instr_rdata);
            end
        end
        report_test("instruction port", start);
    endtask

    task automatic test_gpio();
        int start;
        logic [31:0] rd;
        logic err, seen;
        start = errors;
        access(1'b1, GPIO_OUT_ADDR, 4'hf, 32'hffff_a5c3, rd, err);
        shadow_out = 16'ha5c3;              // Lanes 2 and 3 have no pins.
        check_value("gpio_out after full write", 32'(shadow_out), 32'(gpio_out));
        access(1'b1, GPIO_OUT_ADDR, 4'h2, 32'h0000_3c00, rd, err);
        shadow_out = 16'h3cc3;              // Only the upper byte changes.
        check_value("gpio_out after lane 1 write", 32'(shadow_out), 32'(gpio_out));
        access(1'b0, GPIO_OUT_ADDR, 4'hf, 32'd0, rd, err);
        check_value("gpio_out read back", 32'(shadow_out), rd);
        @(posedge clk);
        gpio_in <= 16'h96e1;
        seen = 1'b0;
        for (int n = 0; n < POLL_LIMIT && !seen; n++) begin
            access(1'b0, GPIO_IN_ADDR, 4'hf, 32'd0, rd, err);
            seen = (rd === 32'h0000_96e1);  // Upper half must read as zero.
        end
        if (!seen) begin
            $display("Timeout: the GPIO input register never returned the pin value 96e1.");
            errors++;
        end
        access(1'b0, GPIO_OUT_ADDR + 32'h8, 4'hf, 32'd0, rd, err);
        check_value("unused GPIO offset", 32'd0, rd);
        report_test("gpio", start);
    endtask

    task automatic test_unmapped();
        int start;
        logic [31:0] rd;
        logic err;
        start = errors;
        access(1'b1, 32'h2000_0080, 4'hf, 32'hdead_beef, rd, err);   // Aliases slot 0.
        check_value("unmapped write data_err", 32'd1, err);
        check_value("unmapped write rdata", 32'd0, rd);
        @(negedge clk);
        check_value("data_err one cycle only", 32'd0, data_err);
        access(1'b0, 32'hf000_0084, 4'hf, 32'd0, rd, err);
        check_value("unmapped read data_err", 32'd1, err);
        check_value("unmapped read rdata", 32'd0, rd);
        for (int i = 0; i < 2; i++) begin
            access(1'b0, ram_addr(i), 4'hf, 32'd0, rd, err);
            check_value("RAM after unmapped access", shadow_word(ram_addr(i)), rd);
        end
        report_test("unmapped region", start);
    endtask

    // Back-to-back random accesses. A write returns the value it replaces.
    task automatic test_random_traffic();
        int start;
        logic [31:0] r, addr, wd, exp_rd, exp_prev;
        logic [GPIO_WIDTH-1:0] exp_out;
        start = errors;
        for (int k = 0; k <= 200; k++) begin
            @(posedge clk);
            exp_out = shadow_out;           // State after access k-1.
            if (k < 200) begin
                r    = next_random();
                wd   = next_random();
                addr = r[0] ? GPIO_OUT_ADDR : ram_addr(r[9:6]);
                drive_access(r[1], addr, r[5:2], wd);
                exp_rd = r[0] ? 32'(shadow_out) : shadow_word(addr);
                if (r[1] && r[0])
                    shadow_out = GPIO_WIDTH'(merge_lanes(32'(shadow_out), wd, r[5:2]));
                else if (r[1])
                    shadow_write(addr, r[5:2], wd);
            end else
                data_req <= 1'b0;
            if (k > 0) begin
                @(negedge clk);
                check_value("random read data", exp_prev, data_rdata);
                check_value("random gpio_out", 32'(exp_out), 32'(gpio_out));
                check_value("random data_err", 32'd0, data_err);
            end
            exp_prev = exp_rd;
        end
        report_test("random traffic", start);
    endtask

    initial begin
        rst_n      = 1'b0;
        data_req   = 1'b0;
        data_we    = 1'b0;
        data_addr  = '0;
        data_be    = '0;
        data_wdata = '0;
        instr_addr = '0;
        gpio_in    = '0;
        shadow_out = '0;
        rnd_state  = 32'hbd93_2820;
        errors     = 0;
        tests_ok   = 0;
        tests_bad  = 0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("gpio_out after reset", 32'd0, 32'(gpio_out));
        check_value("data_err after reset", 32'd0, data_err);
        check_value("data_rdata after reset", 32'd0, data_rdata);
        report_test("reset state", 0);
        test_word_rw();
        test_byte_enables();
        test_instr_port();
        test_gpio();
        test_unmapped();
        test_random_traffic();
        @(posedge clk);
        $display("Summary: %0d tests ok, %0d with errors", tests_ok, tests_bad);
        if (tests_bad == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    // Watchdog in case a test stops making progress.
    initial begin
        repeat (20000) @(posedge clk);
        $display("Timeout: the run did not finish within 20000 clock cycles.");
        $display("Test failed");
        $finish;
    end

endmodule

//--- files.f
common/pmcc_bus_pkg.sv
common/pmcc_mem_pkg.sv
common/pmcc_data_if.sv
ram/pmcc_dpram.sv
rtl/pmcc_data_bus.sv
rtl/pmcc_gpio.sv
rtl/pmcc_mem_top.sv
dv/pmcc_mem_tb.sv
